// File: Bender.yml
package:
  name: rename_unit

sources:
  # Packages first, the types package uses the config package
  - logic/rename_config_pkg.sv
  - logic/rename_types_pkg.sv
  # Rename stage RTL
  - logic/map_table.sv
  - logic/free_list.sv
  - logic/commit_map.sv
  - logic/rename_unit.sv
  # Testbench
  - target: test
    files:
      - test/clock_gen.sv
      - test/rename_assertions.sv
      - test/rename_tb.sv

// File: logic/commit_map.sv
// Committed architectural map with displaced tag release
`timescale 1ns/1ps
`default_nettype none

module commit_map (
    input  logic clock,
    input  logic reset,

    // Retiring instructions, slot 0 is oldest
    input  logic [rename_config_pkg::COMMIT_WIDTH-1:0] commit_valid_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] commit_arch_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] commit_phys_i,

    // Whole committed mapping for recover
    output rename_types_pkg::map_image_t image_o,

    // Tags no longer reachable, one cycle after commit
    output logic [rename_config_pkg::COMMIT_WIDTH-1:0] release_valid_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] release_tag_o
);

    // Committed tag of every architectural register
    rename_types_pkg::map_image_t commit_q;

    // Tag each commit slot displaces
    rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] displaced;

    // ========================================
    // Displaced tag selection
    // ========================================
    // A younger slot on the same register frees the older slot's tag
    always_comb begin
        for (int p = 0; p < rename_config_pkg::COMMIT_WIDTH; p++) begin
            displaced[p] = commit_q[commit_arch_i[p]];
            for (int q = 0; q < p; q++) begin
                if (commit_valid_i[q] && (commit_arch_i[q] == commit_arch_i[p])) begin
                    displaced[p] = commit_phys_i[q];
                end
            end
        end
    end

    // Map update, last slot wins a shared register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
                commit_q[r] <= rename_types_pkg::phys_tag_t'(r);
            end
            release_valid_o <= '0;
        end else begin
            for (int p = 0; p < rename_config_pkg::COMMIT_WIDTH; p++) begin
                if (commit_valid_i[p]) begin
                    commit_q[commit_arch_i[p]] <= commit_phys_i[p];
                end
            end
            release_valid_o <= commit_valid_i;
        end
    end

    // Release tag payload
    always_ff @(posedge clock) begin
        release_tag_o <= displaced;
    end

    // Pre-commit image, a same-cycle commit is not seen by recover
    assign image_o = commit_q;

endmodule

`default_nettype wire

// File: logic/free_list.sv
// Circular free tag queue with speculative and committed heads
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic clock,
    input  logic reset,

    // Allocation for the dispatch group
    input  logic [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_valid_i,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] alloc_fire_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] alloc_tag_o,
    output logic stall_o,

    // Tags freed by the committed map
    input  logic [rename_config_pkg::COMMIT_WIDTH-1:0] release_valid_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] release_tag_i,

    // Committed head tracking and rewind
    input  logic [rename_config_pkg::COMMIT_WIDTH-1:0] commit_valid_i,
    input  logic recover_i
);

    // Pointers carry one extra wrap bit, so full and empty differ
    logic [rename_config_pkg::FREE_PTR_BITS:0] tail_q, tail_d;
    logic [rename_config_pkg::FREE_PTR_BITS:0] spec_head_q, spec_head_d;
    logic [rename_config_pkg::FREE_PTR_BITS:0] commit_head_q, commit_head_d;
    logic [rename_config_pkg::FREE_PTR_BITS:0] count_q, count_d;
    logic [rename_config_pkg::FREE_PTR_BITS:0] rd_ptr;
    logic [rename_config_pkg::FREE_PTR_BITS:0] wr_ptr [rename_config_pkg::COMMIT_WIDTH];
    logic [rename_config_pkg::FREE_PTR_BITS:0] n_req, n_fire, n_commit;
    logic grant;

    rename_types_pkg::phys_tag_t queue_q [rename_config_pkg::FREE_DEPTH];

    // ========================================
    // Group grant
    // ========================================
    always_comb begin
        n_req = '0;
        for (int s = 0; s < rename_config_pkg::DISPATCH_WIDTH; s++) begin
            if (disp_valid_i[s]) n_req = n_req + 1'b1;
        end
    end

    // All or nothing, recover drops the group without a stall
    assign grant        = (count_q >= n_req) && !recover_i;
    assign stall_o      = (count_q < n_req) && !recover_i;
    assign alloc_fire_o = disp_valid_i & {rename_config_pkg::DISPATCH_WIDTH{grant}};
    assign n_fire       = grant ? n_req : '0;

    // Valid slots take consecutive head entries
    always_comb begin
        rd_ptr = spec_head_q;
        for (int s = 0; s < rename_config_pkg::DISPATCH_WIDTH; s++) begin
            alloc_tag_o[s] = queue_q[rd_ptr[rename_config_pkg::FREE_PTR_BITS-1:0]];
            if (disp_valid_i[s]) rd_ptr = rd_ptr + 1'b1;
        end
    end

    // ========================================
    // Release append and pointer updates
    // ========================================
    always_comb begin
        tail_d = tail_q;
        for (int p = 0; p < rename_config_pkg::COMMIT_WIDTH; p++) begin
            wr_ptr[p] = tail_d;
            if (release_valid_i[p]) tail_d = tail_d + 1'b1;
        end
        n_commit = '0;
        for (int p = 0; p < rename_config_pkg::COMMIT_WIDTH; p++) begin
            if (commit_valid_i[p]) n_commit = n_commit + 1'b1;
        end
        // Tags leave in program order, one per committed instruction
        commit_head_d = commit_head_q + n_commit;
        if (recover_i) begin
            spec_head_d = commit_head_q;
            count_d     = tail_d - commit_head_q;
        end else begin
            spec_head_d = spec_head_q + n_fire;
            count_d     = count_q - n_fire + (tail_d - tail_q);
        end
    end

    // Starts full with the tags above the identity range
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rename_config_pkg::FREE_DEPTH; i++) begin
                queue_q[i] <= rename_types_pkg::phys_tag_t'(rename_config_pkg::ARCH_REGS + i);
            end
            tail_q        <= (rename_config_pkg::FREE_PTR_BITS + 1)'(rename_config_pkg::FREE_DEPTH);
            spec_head_q   <= '0;
            commit_head_q <= '0;
            count_q       <= (rename_config_pkg::FREE_PTR_BITS + 1)'(rename_config_pkg::FREE_DEPTH);
        end else begin
            for (int p = 0; p < rename_config_pkg::COMMIT_WIDTH; p++) begin
                if (release_valid_i[p]) begin
                    queue_q[wr_ptr[p][rename_config_pkg::FREE_PTR_BITS-1:0]] <= release_tag_i[p];
                end
            end
            tail_q        <= tail_d;
            spec_head_q   <= spec_head_d;
            commit_head_q <= commit_head_d;
            count_q       <= count_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/map_table.sv
// Speculative register alias table with lookup, rename, writeback scan and restore
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic clock,
    input  logic reset,

    // Destination rename, only fired slots are applied
    input  logic [rename_config_pkg::DISPATCH_WIDTH-1:0] fire_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_arch_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] new_phys_i,

    // Source lookup
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_arch_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_arch_i,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_phys_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_phys_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_ready_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_ready_o,

    // Displaced tags, one cycle after the fire
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_old_phys_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_old_valid_o,

    // Writeback wakeup
    input  logic [rename_config_pkg::WB_WIDTH-1:0] wb_valid_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::WB_WIDTH-1:0] wb_phys_i,

    // Restore from the committed map
    input  logic recover_i,
    input  rename_types_pkg::map_image_t restore_image_i
);

    // Table storage, tag plus ready bit per architectural register
    rename_types_pkg::phys_tag_t map_q [rename_config_pkg::ARCH_REGS];
    rename_types_pkg::phys_tag_t map_d [rename_config_pkg::ARCH_REGS];
    logic [rename_config_pkg::ARCH_REGS-1:0] ready_q;
    logic [rename_config_pkg::ARCH_REGS-1:0] ready_d;

    // Tag each fired slot pushes out of the table
    rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] old_phys;

    // ========================================
    // Source lookup with in-group bypass
    // ========================================
    always_comb begin
        for (int s = 0; s < rename_config_pkg::DISPATCH_WIDTH; s++) begin
            src1_phys_o[s]  = map_q[src1_arch_i[s]];
            src1_ready_o[s] = ready_q[src1_arch_i[s]];
            src2_phys_o[s]  = map_q[src2_arch_i[s]];
            src2_ready_o[s] = ready_q[src2_arch_i[s]];
            // Older slot writing our source wins, youngest match last
            for (int p = 0; p < s; p++) begin
                if (fire_i[p] && (disp_arch_i[p] == src1_arch_i[s])) begin
                    src1_phys_o[s]  = new_phys_i[p];
                    src1_ready_o[s] = 1'b0;
                end
                if (fire_i[p] && (disp_arch_i[p] == src2_arch_i[s])) begin
                    src2_phys_o[s]  = new_phys_i[p];
                    src2_ready_o[s] = 1'b0;
                end
            end
        end
    end

    // Displaced tag, chained through older slots with the same destination
    always_comb begin
        for (int s = 0; s < rename_config_pkg::DISPATCH_WIDTH; s++) begin
            old_phys[s] = map_q[disp_arch_i[s]];
            for (int p = 0; p < s; p++) begin
                if (fire_i[p] && (disp_arch_i[p] == disp_arch_i[s])) begin
                    old_phys[s] = new_phys_i[p];
                end
            end
        end
    end

    // ========================================
    // Next table state
    // ========================================
    always_comb begin
        map_d   = map_q;
        ready_d = ready_q;
        // Wakeup scans the current tags, so a same-cycle rename is not woken
        for (int w = 0; w < rename_config_pkg::WB_WIDTH; w++) begin
            if (wb_valid_i[w]) begin
                for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
                    if (map_q[r] == wb_phys_i[w]) begin
                        ready_d[r] = 1'b1;
                    end
                end
            end
        end
        // Rename in slot order, later slot owns a shared destination
        for (int s = 0; s < rename_config_pkg::DISPATCH_WIDTH; s++) begin
            if (fire_i[s]) begin
                map_d[disp_arch_i[s]]   = new_phys_i[s];
                ready_d[disp_arch_i[s]] = 1'b0;
            end
        end
        // Recover overrides everything, committed values are all ready
        if (recover_i) begin
            for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
                map_d[r] = restore_image_i[r];
            end
            ready_d = '1;
        end
    end

    // Identity mapping out of reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
                map_q[r] <= rename_types_pkg::phys_tag_t'(r);
            end
            ready_q          <= '1;
            disp_old_valid_o <= '0;
        end else begin
            for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
                map_q[r] <= map_d[r];
            end
            ready_q          <= ready_d;
            disp_old_valid_o <= fire_i & {rename_config_pkg::DISPATCH_WIDTH{~recover_i}};
        end
    end

    // Old tag payload, qualified by disp_old_valid_o
    always_ff @(posedge clock) begin
        disp_old_phys_o <= old_phys;
    end

endmodule

`default_nettype wire

// File: logic/rename_config_pkg.sv
// Sizes and derived widths of the register rename subsystem
`default_nettype none

package rename_config_pkg;

    // ========================================
    // Register file sizes
    // ========================================
    localparam int ARCH_REGS = 16;
    localparam int PHYS_REGS = 48;

    // ========================================
    // Pipeline widths
    // ========================================
    // Instructions renamed per cycle
    localparam int DISPATCH_WIDTH = 2;
    localparam int WB_WIDTH       = 2;
    localparam int COMMIT_WIDTH   = 2;

    // Tags not held by the committed map live in the free list
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // Derived index widths
    localparam int ARCH_BITS     = $clog2(ARCH_REGS);
    localparam int PHYS_BITS     = $clog2(PHYS_REGS);
    localparam int FREE_PTR_BITS = $clog2(FREE_DEPTH);

endpackage

`default_nettype wire

// File: logic/rename_types_pkg.sv
// Architectural index, physical tag and map image types
`default_nettype none

package rename_types_pkg;

    // ========================================
    // Register identifiers
    // ========================================
    // Architectural register number as seen by the ISA
    typedef logic [rename_config_pkg::ARCH_BITS-1:0] arch_tag_t;

    // Physical register tag, also used as the wakeup tag
    typedef logic [rename_config_pkg::PHYS_BITS-1:0] phys_tag_t;

    // ========================================
    // Whole-table images
    // ========================================
    // One physical tag per architectural register
    // Index i holds the tag of architectural register i
    // Used to copy the committed map back into the speculative table
    typedef phys_tag_t [rename_config_pkg::ARCH_REGS-1:0] map_image_t;

endpackage

`default_nettype wire

// File: logic/rename_unit.sv
// Rename stage top with alias table, free list and committed map
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic clock,
    input  logic reset,

    // ========================================
    // Dispatch group
    // ========================================
    input  logic [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_valid_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_arch_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_arch_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_arch_i,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_phys_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_phys_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] src1_ready_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] src2_ready_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_new_phys_o,
    output rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_old_phys_o,
    output logic [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_old_valid_o,
    output logic stall_o,

    // Writeback, commit and recover
    input  logic [rename_config_pkg::WB_WIDTH-1:0] wb_valid_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::WB_WIDTH-1:0] wb_phys_i,
    input  logic [rename_config_pkg::COMMIT_WIDTH-1:0] commit_valid_i,
    input  rename_types_pkg::arch_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] commit_arch_i,
    input  rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] commit_phys_i,
    input  logic recover_i
);

    // Granted slots and their fresh tags
    logic [rename_config_pkg::DISPATCH_WIDTH-1:0] alloc_fire;
    rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] alloc_tag;

    // Committed map back to the free list and the table
    logic [rename_config_pkg::COMMIT_WIDTH-1:0] release_valid;
    rename_types_pkg::phys_tag_t [rename_config_pkg::COMMIT_WIDTH-1:0] release_tag;
    rename_types_pkg::map_image_t commit_image;

    assign disp_new_phys_o = alloc_tag;

    map_table i_map_table (
        .clock            (clock),
        .reset            (reset),
        .fire_i           (alloc_fire),
        .disp_arch_i      (disp_arch_i),
        .new_phys_i       (alloc_tag),
        .src1_arch_i      (src1_arch_i),
        .src2_arch_i      (src2_arch_i),
        .src1_phys_o      (src1_phys_o),
        .src2_phys_o      (src2_phys_o),
        .src1_ready_o     (src1_ready_o),
        .src2_ready_o     (src2_ready_o),
        .disp_old_phys_o  (disp_old_phys_o),
        .disp_old_valid_o (disp_old_valid_o),
        .wb_valid_i       (wb_valid_i),
        .wb_phys_i        (wb_phys_i),
        .recover_i        (recover_i),
        .restore_image_i  (commit_image)
    );

    free_list i_free_list (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .alloc_fire_o    (alloc_fire),
        .alloc_tag_o     (alloc_tag),
        .stall_o         (stall_o),
        .release_valid_i (release_valid),
        .release_tag_i   (release_tag),
        .commit_valid_i  (commit_valid_i),
        .recover_i       (recover_i)
    );

    commit_map i_commit_map (
        .clock           (clock),
        .reset           (reset),
        .commit_valid_i  (commit_valid_i),
        .commit_arch_i   (commit_arch_i),
        .commit_phys_i   (commit_phys_i),
        .image_o         (commit_image),
        .release_valid_o (release_valid),
        .release_tag_o   (release_tag)
    );

endmodule

`default_nettype wire

// File: project.f
logic/rename_config_pkg.sv
logic/rename_types_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/commit_map.sv
logic/rename_unit.sv
test/clock_gen.sv
test/rename_assertions.sv
test/rename_tb.sv

// File: test/clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    // 40 ns period
    initial begin
        clock_o = 1'b0;
        forever #20 clock_o = ~clock_o;
    end

    // Reset held for four rising edges, released off the edge
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clock_o);
        #2 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: test/rename_assertions.sv
// Concurrent protocol assertions for the rename stage and their bind
`timescale 1ns/1ps
`default_nettype none

module rename_assertions (
    input logic clock,
    input logic reset,
    input logic [rename_config_pkg::DISPATCH_WIDTH-1:0] alloc_fire_i,
    input rename_types_pkg::phys_tag_t [rename_config_pkg::DISPATCH_WIDTH-1:0] new_phys_i,
    input logic [rename_config_pkg::DISPATCH_WIDTH-1:0] disp_old_valid_i,
    input logic stall_i
);

    // Assertion failures seen during the run
    int failures = 0;

    // ========================================
    // Allocation rules
    // ========================================
    // A stalled group leaves no displaced tag behind in the table
    stall_blocks_fire: assert property (@(posedge clock) disable iff (reset)
        stall_i |=> (disp_old_valid_i == '0))
        else begin
            failures++;
            $error("Allocation fired while stall_o was high");
        end

    // Both slots granted must get different tags
    distinct_tags: assert property (@(posedge clock) disable iff (reset)
        (&alloc_fire_i) |-> (new_phys_i[0] != new_phys_i[1]))
        else begin
            failures++;
            $error("Both dispatch slots received the same tag");
        end

    // ========================================
    // Old tag timing and reset state
    // ========================================
    old_valid_timing: assert property (@(posedge clock) disable iff (reset)
        disp_old_valid_i == $past(alloc_fire_i))
        else begin
            failures++;
            $error("disp_old_valid_o did not follow the fire by one cycle");
        end

    reset_outputs_low: assert property (@(posedge clock)
        $fell(reset) |-> (!stall_i && (disp_old_valid_i == '0)))
        else begin
            failures++;
            $error("stall_o or disp_old_valid_o high after reset");
        end

endmodule

bind rename_unit rename_assertions i_assertions (
    .clock            (clock),
    .reset            (reset),
    .alloc_fire_i     (alloc_fire),
    .new_phys_i       (alloc_tag),
    .disp_old_valid_i (disp_old_valid_o),
    .stall_i          (stall_o)
);

`default_nettype wire

// File: test/rename_tb.sv
// Rename stage testbench with reference model, directed and random tests, timeout
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

    // Generous bound on the length of the test sequence
    localparam int TIMEOUT_CYCLES = 1500;

    logic clock;
    logic reset;
    logic [1:0] disp_valid;
    rename_types_pkg::arch_tag_t [1:0] disp_arch;
    rename_types_pkg::arch_tag_t [1:0] src1_arch;
    rename_types_pkg::arch_tag_t [1:0] src2_arch;
    rename_types_pkg::phys_tag_t [1:0] src1_phys;
    rename_types_pkg::phys_tag_t [1:0] src2_phys;
    logic [1:0] src1_ready;
    logic [1:0] src2_ready;
    rename_types_pkg::phys_tag_t [1:0] new_phys;
    rename_types_pkg::phys_tag_t [1:0] old_phys;
    logic [1:0] old_valid;
    logic stall;
    logic [1:0] wb_valid;
    rename_types_pkg::phys_tag_t [1:0] wb_phys;
    logic [1:0] commit_valid;
    rename_types_pkg::arch_tag_t [1:0] commit_arch;
    rename_types_pkg::phys_tag_t [1:0] commit_phys;
    logic recover;

    // ========================================
    // Reference model state
    // ========================================
    int map_model [rename_config_pkg::ARCH_REGS];
    logic ready_model [rename_config_pkg::ARCH_REGS];
    int commit_model [rename_config_pkg::ARCH_REGS];
    // Every tag ever queued in order of entry
    int free_tags [$];
    int spec_idx;
    int commit_idx;
    // In-flight instructions in program order
    int rob_arch [$];
    int rob_phys [$];

    int seed = 32'h3c43;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start_errors = 0;
    int cycles = 0;

    clock_gen i_clock_gen (.clock_o(clock), .reset_o(reset));

    rename_unit i_dut (
        .clock (clock), .reset (reset),
        .disp_valid_i (disp_valid), .disp_arch_i (disp_arch),
        .src1_arch_i (src1_arch), .src2_arch_i (src2_arch),
        .src1_phys_o (src1_phys), .src2_phys_o (src2_phys),
        .src1_ready_o (src1_ready), .src2_ready_o (src2_ready),
        .disp_new_phys_o (new_phys), .disp_old_phys_o (old_phys),
        .disp_old_valid_o (old_valid), .stall_o (stall),
        .wb_valid_i (wb_valid), .wb_phys_i (wb_phys),
        .commit_valid_i (commit_valid), .commit_arch_i (commit_arch),
        .commit_phys_i (commit_phys), .recover_i (recover)
    );

    // Hard stop if the run never reaches its end
    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // Lands 2 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    function automatic int rand_arch();
        return $unsigned($random(seed)) % rename_config_pkg::ARCH_REGS;
    endfunction

    // Four registers per cycle across the four lookup ports
    task automatic check_all_lookups();
        for (int c = 0; c < rename_config_pkg::ARCH_REGS / 4; c++) begin
            src1_arch[0] = 4 * c;
            src2_arch[0] = 4 * c + 1;
            src1_arch[1] = 4 * c + 2;
            src2_arch[1] = 4 * c + 3;
            #1;
            for (int s = 0; s < 2; s++) begin
                check_value($sformatf("src1_phys_o[%0d]", s), src1_phys[s],
                            map_model[src1_arch[s]]);
                check_value($sformatf("src1_ready_o[%0d]", s), src1_ready[s],
                            ready_model[src1_arch[s]]);
                check_value($sformatf("src2_phys_o[%0d]", s), src2_phys[s],
                            map_model[src2_arch[s]]);
                check_value($sformatf("src2_ready_o[%0d]", s), src2_ready[s],
                            ready_model[src2_arch[s]]);
            end
            next_cycle();
        end
    endtask

    // ========================================
    // Dispatch, writeback, commit, recover
    // ========================================
    task automatic dispatch_group(input logic [1:0] valid, input int dst0, input int dst1,
                                  input int a1_0, input int a2_0, input int a1_1, input int a2_1);
        int dst [2];
        int src [2][2];
        int new_tag [2];
        int exp_old [2];
        int exp_tag;
        logic exp_rdy;
        logic exp_stall;
        logic [1:0] exp_fire;
        int next_idx;
        dst[0] = dst0;
        dst[1] = dst1;
        src[0][0] = a1_0;
        src[0][1] = a2_0;
        src[1][0] = a1_1;
        src[1][1] = a2_1;
        for (int k = 0; k < 2; k++) begin
            disp_valid[k] = valid[k];
            disp_arch[k]  = dst[k];
            src1_arch[k]  = src[k][0];
            src2_arch[k]  = src[k][1];
        end
        #1;
        // Whole group or nothing
        exp_stall = (free_tags.size() - spec_idx) < $countones(valid);
        exp_fire  = exp_stall ? 2'b00 : valid;
        check_value("stall_o", stall, exp_stall);
        next_idx = spec_idx;
        for (int k = 0; k < 2; k++) begin
            new_tag[k] = 0;
            if (exp_fire[k]) begin
                new_tag[k] = free_tags[next_idx];
                next_idx++;
                check_value($sformatf("disp_new_phys_o[%0d]", k), new_phys[k], new_tag[k]);
            end
        end
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 2; j++) begin
                exp_tag = map_model[src[k][j]];
                exp_rdy = ready_model[src[k][j]];
                // Slot 1 sees slot 0's fresh destination
                if (k == 1 && exp_fire[0] && dst[0] == src[k][j]) begin
                    exp_tag = new_tag[0];
                    exp_rdy = 1'b0;
                end
                check_value($sformatf("src%0d_phys_o[%0d]", j + 1, k),
                            (j == 0) ? src1_phys[k] : src2_phys[k], exp_tag);
                check_value($sformatf("src%0d_ready_o[%0d]", j + 1, k),
                            (j == 0) ? src1_ready[k] : src2_ready[k], exp_rdy);
            end
        end
        // Slot order update lets a shared destination chain naturally
        for (int k = 0; k < 2; k++) begin
            if (exp_fire[k]) begin
                exp_old[k] = map_model[dst[k]];
                map_model[dst[k]] = new_tag[k];
                ready_model[dst[k]] = 1'b0;
                rob_arch.push_back(dst[k]);
                rob_phys.push_back(new_tag[k]);
                spec_idx++;
            end
        end
        next_cycle();
        disp_valid = '0;
        check_value("disp_old_valid_o", old_valid, exp_fire);
        for (int k = 0; k < 2; k++) begin
            if (exp_fire[k]) begin
                check_value($sformatf("disp_old_phys_o[%0d]", k), old_phys[k], exp_old[k]);
            end
        end
    endtask

    task automatic random_group();
        dispatch_group(2'b11, rand_arch(), rand_arch(), rand_arch(), rand_arch(),
                       rand_arch(), rand_arch());
    endtask

    task automatic writeback_pair(input int tag0, input int tag1, input int watch);
        wb_valid     = 2'b11;
        wb_phys[0]   = tag0;
        wb_phys[1]   = tag1;
        src1_arch[0] = watch;
        #1;
        // Same-cycle lookup still sees the old ready bit
        check_value("src1_ready_o[0] in writeback cycle", src1_ready[0], ready_model[watch]);
        for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
            if (map_model[r] == tag0 || map_model[r] == tag1) ready_model[r] = 1'b1;
        end
        next_cycle();
        wb_valid = '0;
        check_all_lookups();
    endtask

    // Oldest n instructions retire and their released tags land two edges later
    task automatic commit_group(input int n);
        for (int k = 0; k < n; k++) begin
            commit_valid[k] = 1'b1;
            commit_arch[k]  = rob_arch.pop_front();
            commit_phys[k]  = rob_phys.pop_front();
            free_tags.push_back(commit_model[commit_arch[k]]);
            commit_model[commit_arch[k]] = commit_phys[k];
        end
        commit_idx += n;
        next_cycle();
        commit_valid = '0;
        next_cycle();
    endtask

    task automatic recover_pulse();
        recover    = 1'b1;
        disp_valid = 2'b11;
        #1;
        check_value("stall_o during recover", stall, 0);
        next_cycle();
        recover    = 1'b0;
        disp_valid = '0;
        check_value("disp_old_valid_o after recover", old_valid, 0);
        for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
            map_model[r]   = commit_model[r];
            ready_model[r] = 1'b1;
        end
        spec_idx = commit_idx;
        rob_arch.delete();
        rob_phys.delete();
        check_all_lookups();
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        disp_valid   = '0;
        disp_arch    = '0;
        src1_arch    = '0;
        src2_arch    = '0;
        wb_valid     = '0;
        wb_phys      = '0;
        commit_valid = '0;
        commit_arch  = '0;
        commit_phys  = '0;
        recover      = 1'b0;
        for (int r = 0; r < rename_config_pkg::ARCH_REGS; r++) begin
            map_model[r]    = r;
            ready_model[r]  = 1'b1;
            commit_model[r] = r;
        end
        for (int t = rename_config_pkg::ARCH_REGS; t < rename_config_pkg::PHYS_REGS; t++) begin
            free_tags.push_back(t);
        end
        spec_idx   = 0;
        commit_idx = 0;
        @(negedge reset);
        next_cycle();

        check_value("stall_o after reset", stall, 0);
        check_all_lookups();
        finish_test("reset identity");

        for (int g = 0; g < 10; g++) random_group();
        // Same destination in both slots with slot 1 reading it as a source
        dispatch_group(2'b11, 3, 3, 3, 7, 3, 9);
        // Slot 1 reads slot 0's destination on both sources
        dispatch_group(2'b11, 5, 11, 2, 5, 5, 5);
        check_all_lookups();
        finish_test("rename and bypass");

        writeback_pair(rob_phys[rob_phys.size() - 1], rob_phys[rob_phys.size() - 2],
                       rob_arch[rob_arch.size() - 1]);
        finish_test("writeback wakeup");

        while (free_tags.size() - spec_idx >= 2) random_group();
        random_group();
        commit_group(1);
        random_group();
        commit_group(1);
        random_group();
        finish_test("free list stall");

        commit_group(2);
        commit_group(2);
        random_group();
        random_group();
        // First pulse with an empty free list shows stall_o held low
        recover_pulse();
        // Second pulse with free tags available shows the group dropped
        recover_pulse();
        random_group();
        finish_test("recover");

        next_cycle();
        next_cycle();
        $display("tests %0d checks %0d errors %0d assertion failures %0d",
                 tests, checks, errors, i_dut.i_assertions.failures);
        if (errors == 0 && i_dut.i_assertions.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
